//--- verilog.f
+incdir+.
rf_pkg.sv
reg_file.sv
operand_forward.sv
pipe_stage_reg.sv
rf_stage_top.sv
tb_rf_stage.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_rf_stage
FILELIST  ?= verilog.f

OBJ_DIR = obj_dir
SIM     = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(SIM): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_tasks.svh
task automatic check(input string name, input quad_t exp, input quad_t act);
  assert (act === exp) else begin
    $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    errors++;
  end
endtask

function automatic quad_t rand_quad();
  logic [31:0] w0, w1, w2, w3;
  w0 = $random(seed);
  w1 = $random(seed);
  w2 = $random(seed);
  w3 = $random(seed);
  return {w0, w1, w2, w3};
endfunction

task automatic clear_inputs();
  flush = 1'b0;
  {full_instr_even, instr_id_even, reg_dst_even, unit_id_even, latency_even} = '0;
  {full_instr_odd, instr_id_odd, reg_dst_odd, unit_id_odd, latency_odd} = '0;
  reg_wr_even = 1'b0;
  reg_wr_odd = 1'b0;
  {ra_addr_even, rb_addr_even, rc_addr_even} = '0;
  {ra_addr_odd, rb_addr_odd, rc_addr_odd} = '0;
  for (int s = 0; s < stages; s++) begin
    fw_wr_even[s] = 1'b0;
    fw_addr_even[s] = '0;
    fw_data_even[s] = '0;
    fw_wr_odd[s] = 1'b0;
    fw_addr_odd[s] = '0;
    fw_data_odd[s] = '0;
  end
  {wr_en_1, wr_en_2} = 2'b00;
  {wr_addr_1, wr_addr_2} = '0;
  {wr_data_1, wr_data_2} = '0;
endtask

// one clock of prediction, model update and output check
task automatic run_cycle();
  quad_t e_ops [0:5];
  quad_t e_fi [0:1];
  quad_t e_id [0:1];
  quad_t e_dst [0:1];
  quad_t e_unit [0:1];
  quad_t e_lat [0:1];
  quad_t e_wr [0:1];
  e_ops[0] = expect_operand(ra_addr_even, 1'b0);
  e_ops[1] = expect_operand(rb_addr_even, 1'b0);
  e_ops[2] = expect_operand(rc_addr_even, 1'b0);
  e_ops[3] = expect_operand(ra_addr_odd, 1'b1);
  e_ops[4] = expect_operand(rb_addr_odd, 1'b1);
  e_ops[5] = expect_operand(rc_addr_odd, 1'b1);
  e_fi[0] = quad_t'(full_instr_even);
  e_fi[1] = quad_t'(full_instr_odd);
  e_id[0] = quad_t'(instr_id_even);
  e_id[1] = quad_t'(instr_id_odd);
  e_dst[0] = quad_t'(reg_dst_even);
  e_dst[1] = quad_t'(reg_dst_odd);
  e_unit[0] = quad_t'(unit_id_even);
  e_unit[1] = quad_t'(unit_id_odd);
  e_lat[0] = quad_t'(latency_even);
  e_lat[1] = quad_t'(latency_odd);
  e_wr[0] = quad_t'(reg_wr_even);
  e_wr[1] = quad_t'(reg_wr_odd);
  if (flush) begin
    for (int i = 0; i < 6; i++) e_ops[i] = '0;
    for (int p = 0; p < 2; p++) begin
      {e_fi[p], e_dst[p], e_unit[p], e_lat[p], e_wr[p]} = '0;
    end
    e_id[0] = quad_t'(even_nop_id);
    e_id[1] = quad_t'(odd_nop_id);
  end
  // port 2 applied last so it wins
  if (wr_en_1) ref_regs[wr_addr_1] = wr_data_1;
  if (wr_en_2) ref_regs[wr_addr_2] = wr_data_2;
  wait_falls(1, "output cycle");
  check("out_full_instr_even", e_fi[0], quad_t'(out_full_instr_even));
  check("out_instr_id_even", e_id[0], quad_t'(out_instr_id_even));
  check("out_reg_dst_even", e_dst[0], quad_t'(out_reg_dst_even));
  check("out_unit_id_even", e_unit[0], quad_t'(out_unit_id_even));
  check("out_latency_even", e_lat[0], quad_t'(out_latency_even));
  check("out_reg_wr_even", e_wr[0], quad_t'(out_reg_wr_even));
  check("out_full_instr_odd", e_fi[1], quad_t'(out_full_instr_odd));
  check("out_instr_id_odd", e_id[1], quad_t'(out_instr_id_odd));
  check("out_reg_dst_odd", e_dst[1], quad_t'(out_reg_dst_odd));
  check("out_unit_id_odd", e_unit[1], quad_t'(out_unit_id_odd));
  check("out_latency_odd", e_lat[1], quad_t'(out_latency_odd));
  check("out_reg_wr_odd", e_wr[1], quad_t'(out_reg_wr_odd));
  check("ra_data_even", e_ops[0], ra_data_even);
  check("rb_data_even", e_ops[1], rb_data_even);
  check("rc_data_even", e_ops[2], rc_data_even);
  check("ra_data_odd", e_ops[3], ra_data_odd);
  check("rb_data_odd", e_ops[4], rb_data_odd);
  check("rc_data_odd", e_ops[5], rc_data_odd);
endtask

task automatic set_all_src(input reg_addr_t a);
  {ra_addr_even, rb_addr_even, rc_addr_even} = {a, a, a};
  {ra_addr_odd, rb_addr_odd, rc_addr_odd} = {a, a, a};
endtask

task automatic test_reset_state();
  check("out_full_instr_even", '0, quad_t'(out_full_instr_even));
  check("out_instr_id_even", '0, quad_t'(out_instr_id_even));
  check("out_reg_dst_even", '0, quad_t'(out_reg_dst_even));
  check("out_unit_id_even", '0, quad_t'(out_unit_id_even));
  check("out_latency_even", '0, quad_t'(out_latency_even));
  check("out_reg_wr_even", '0, quad_t'(out_reg_wr_even));
  check("out_full_instr_odd", '0, quad_t'(out_full_instr_odd));
  check("out_instr_id_odd", '0, quad_t'(out_instr_id_odd));
  check("out_reg_dst_odd", '0, quad_t'(out_reg_dst_odd));
  check("out_unit_id_odd", '0, quad_t'(out_unit_id_odd));
  check("out_latency_odd", '0, quad_t'(out_latency_odd));
  check("out_reg_wr_odd", '0, quad_t'(out_reg_wr_odd));
  check("ra_data_even", '0, ra_data_even);
  check("rb_data_even", '0, rb_data_even);
  check("rc_data_even", '0, rc_data_even);
  check("ra_data_odd", '0, ra_data_odd);
  check("rb_data_odd", '0, rb_data_odd);
  check("rc_data_odd", '0, rc_data_odd);
  clear_inputs();
  run_cycle();
endtask

task automatic test_write_read();
  quad_t port2_data;
  clear_inputs();
  {wr_en_1, wr_en_2} = 2'b11;
  wr_addr_1 = 7'd5;
  wr_data_1 = rand_quad();
  wr_addr_2 = 7'd9;
  wr_data_2 = rand_quad();
  run_cycle();
  clear_inputs();
  // dual write to one address
  {wr_en_1, wr_en_2} = 2'b11;
  {wr_addr_1, wr_addr_2} = {7'd12, 7'd12};
  wr_data_1 = rand_quad();
  wr_data_2 = rand_quad();
  port2_data = wr_data_2;
  ra_addr_even = 7'd5;
  rb_addr_even = 7'd9;
  rc_addr_even = 7'd12;
  ra_addr_odd = 7'd9;
  rb_addr_odd = 7'd5;
  rc_addr_odd = 7'd12;
  full_instr_even = 32'hdeadbeef;
  instr_id_even = 7'd33;
  reg_dst_even = 7'd70;
  unit_id_even = 3'd5;
  latency_even = 4'd6;
  reg_wr_even = 1'b1;
  full_instr_odd = 32'h12345678;
  instr_id_odd = 7'd101;
  reg_dst_odd = 7'd3;
  unit_id_odd = 3'd2;
  latency_odd = 4'd9;
  reg_wr_odd = 1'b1;
  run_cycle();
  clear_inputs();
  set_all_src(7'd12);
  run_cycle();
  check("ra_data_even port 2", port2_data, ra_data_even);
  check("rc_data_odd port 2", port2_data, rc_data_odd);
endtask

task automatic test_forward_priority();
  clear_inputs();
  wr_en_1 = 1'b1;
  wr_addr_1 = 7'd20;
  wr_data_1 = rand_quad();
  run_cycle();
  // younger stage beats older
  clear_inputs();
  set_all_src(7'd20);
  {fw_wr_even[4], fw_addr_even[4], fw_data_even[4]} = {1'b1, 7'd20, rand_quad()};
  {fw_wr_even[1], fw_addr_even[1], fw_data_even[1]} = {1'b1, 7'd20, rand_quad()};
  {fw_wr_odd[3], fw_addr_odd[3], fw_data_odd[3]} = {1'b1, 7'd20, rand_quad()};
  run_cycle();
  check("ra_data_even young", fw_data_even[1], ra_data_even);
  // own pipe wins within a stage
  clear_inputs();
  set_all_src(7'd20);
  {fw_wr_even[2], fw_addr_even[2], fw_data_even[2]} = {1'b1, 7'd20, rand_quad()};
  {fw_wr_odd[2], fw_addr_odd[2], fw_data_odd[2]} = {1'b1, 7'd20, rand_quad()};
  run_cycle();
  check("rc_data_odd own", fw_data_odd[2], rc_data_odd);
  // other pipe only match in each direction
  clear_inputs();
  set_all_src(7'd20);
  {fw_wr_even[5], fw_addr_even[5], fw_data_even[5]} = {1'b1, 7'd20, rand_quad()};
  run_cycle();
  clear_inputs();
  set_all_src(7'd20);
  {fw_wr_odd[0], fw_addr_odd[0], fw_data_odd[0]} = {1'b1, 7'd20, rand_quad()};
  run_cycle();
  check("rb_data_even other", fw_data_odd[0], rb_data_even);
endtask

task automatic test_disabled_entry();
  clear_inputs();
  set_all_src(7'd20);
  {fw_wr_even[0], fw_addr_even[0], fw_data_even[0]} = {1'b0, 7'd20, rand_quad()};
  {fw_wr_odd[0], fw_addr_odd[0], fw_data_odd[0]} = {1'b0, 7'd20, rand_quad()};
  run_cycle();
  check("ra_data_even regfile", ref_regs[20], ra_data_even);
endtask

task automatic test_flush();
  clear_inputs();
  set_all_src(7'd5);
  full_instr_even = 32'hcafef00d;
  instr_id_even = 7'd17;
  reg_dst_even = 7'd2;
  unit_id_even = 3'd3;
  latency_even = 4'd4;
  reg_wr_even = 1'b1;
  full_instr_odd = 32'h0badf00d;
  instr_id_odd = 7'd44;
  reg_dst_odd = 7'd8;
  unit_id_odd = 3'd6;
  latency_odd = 4'd7;
  reg_wr_odd = 1'b1;
  flush = 1'b1;
  run_cycle();
  flush = 1'b0;
  run_cycle();
endtask

task automatic test_random();
  logic [31:0] r;
  for (int c = 0; c < 200; c++) begin
    clear_inputs();
    r = $random(seed);
    // small address range so forwarding hits often
    ra_addr_even = {3'b000, r[3:0]};
    rb_addr_even = {3'b000, r[7:4]};
    rc_addr_even = {3'b000, r[11:8]};
    ra_addr_odd = {3'b000, r[15:12]};
    rb_addr_odd = {3'b000, r[19:16]};
    rc_addr_odd = {3'b000, r[23:20]};
    wr_en_1 = r[24];
    wr_en_2 = r[25];
    flush = (r[31:28] == 4'hf);
    r = $random(seed);
    wr_addr_1 = {3'b000, r[3:0]};
    wr_addr_2 = {3'b000, r[7:4]};
    full_instr_even = $random(seed);
    full_instr_odd = $random(seed);
    {instr_id_even, reg_dst_even, unit_id_even, latency_even, reg_wr_even} = r[31:10];
    wr_data_1 = rand_quad();
    wr_data_2 = rand_quad();
    for (int s = 0; s < stages; s++) begin
      r = $random(seed);
      {fw_wr_even[s], fw_wr_odd[s]} = r[1:0];
      fw_addr_even[s] = {3'b000, r[5:2]};
      fw_addr_odd[s] = {3'b000, r[9:6]};
      fw_data_even[s] = rand_quad();
      fw_data_odd[s] = rand_quad();
    end
    run_cycle();
  end
endtask

//--- tb_rf_stage.sv
`timescale 1ns/1ns

module tb_rf_stage;

  import rf_pkg::*;

  localparam int clk_half = 20;
  localparam int timeout_ns = 1000;
  localparam int stages = num_fw_stages;

  integer seed = 32'h2c92;
  int errors = 0;
  int fall_count = 0;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic flush;

  instr_t    full_instr_even, full_instr_odd;
  instr_id_t instr_id_even, instr_id_odd;
  reg_addr_t reg_dst_even, reg_dst_odd;
  unit_id_t  unit_id_even, unit_id_odd;
  latency_t  latency_even, latency_odd;
  logic      reg_wr_even, reg_wr_odd;
  reg_addr_t ra_addr_even, rb_addr_even, rc_addr_even;
  reg_addr_t ra_addr_odd, rb_addr_odd, rc_addr_odd;

  logic      fw_wr_even   [0:stages-1];
  reg_addr_t fw_addr_even [0:stages-1];
  quad_t     fw_data_even [0:stages-1];
  logic      fw_wr_odd    [0:stages-1];
  reg_addr_t fw_addr_odd  [0:stages-1];
  quad_t     fw_data_odd  [0:stages-1];

  logic      wr_en_1, wr_en_2;
  reg_addr_t wr_addr_1, wr_addr_2;
  quad_t     wr_data_1, wr_data_2;

  instr_t    out_full_instr_even, out_full_instr_odd;
  instr_id_t out_instr_id_even, out_instr_id_odd;
  reg_addr_t out_reg_dst_even, out_reg_dst_odd;
  unit_id_t  out_unit_id_even, out_unit_id_odd;
  latency_t  out_latency_even, out_latency_odd;
  logic      out_reg_wr_even, out_reg_wr_odd;
  quad_t     ra_data_even, rb_data_even, rc_data_even;
  quad_t     ra_data_odd, rb_data_odd, rc_data_odd;

  // reference copy of the register file
  quad_t ref_regs [0:num_regs-1];

  always #(clk_half) clk = ~clk;

  always @(negedge clk) fall_count <= fall_count + 1;

  rf_stage_top #(.num_fw_stages(stages)) dut0 (
    .clk(clk), .rst(rst), .flush(flush),
    .full_instr_even(full_instr_even), .instr_id_even(instr_id_even),
    .reg_dst_even(reg_dst_even), .unit_id_even(unit_id_even),
    .latency_even(latency_even), .reg_wr_even(reg_wr_even),
    .ra_addr_even(ra_addr_even), .rb_addr_even(rb_addr_even),
    .rc_addr_even(rc_addr_even),
    .full_instr_odd(full_instr_odd), .instr_id_odd(instr_id_odd),
    .reg_dst_odd(reg_dst_odd), .unit_id_odd(unit_id_odd),
    .latency_odd(latency_odd), .reg_wr_odd(reg_wr_odd),
    .ra_addr_odd(ra_addr_odd), .rb_addr_odd(rb_addr_odd),
    .rc_addr_odd(rc_addr_odd),
    .fw_wr_even(fw_wr_even), .fw_addr_even(fw_addr_even), .fw_data_even(fw_data_even),
    .fw_wr_odd(fw_wr_odd), .fw_addr_odd(fw_addr_odd), .fw_data_odd(fw_data_odd),
    .wr_en_1(wr_en_1), .wr_en_2(wr_en_2), .wr_addr_1(wr_addr_1), .wr_addr_2(wr_addr_2),
    .wr_data_1(wr_data_1), .wr_data_2(wr_data_2),
    .out_full_instr_even(out_full_instr_even), .out_instr_id_even(out_instr_id_even),
    .out_reg_dst_even(out_reg_dst_even), .out_unit_id_even(out_unit_id_even),
    .out_latency_even(out_latency_even), .out_reg_wr_even(out_reg_wr_even),
    .ra_data_even(ra_data_even), .rb_data_even(rb_data_even), .rc_data_even(rc_data_even),
    .out_full_instr_odd(out_full_instr_odd), .out_instr_id_odd(out_instr_id_odd),
    .out_reg_dst_odd(out_reg_dst_odd), .out_unit_id_odd(out_unit_id_odd),
    .out_latency_odd(out_latency_odd), .out_reg_wr_odd(out_reg_wr_odd),
    .ra_data_odd(ra_data_odd), .rb_data_odd(rb_data_odd), .rc_data_odd(rc_data_odd)
  );

  // waits for n falling edges, gives up after timeout_ns
  task automatic wait_falls(input int n, input string what);
    int target;
    int waited;
    target = fall_count + n;
    waited = 0;
    while (fall_count < target && waited < timeout_ns * n) begin
      #1;
      waited++;
    end
    if (fall_count < target) begin
      $display("Timeout at %0t: clock stopped while waiting for %s", $time, what);
      $display("TEST FAILED");
      $finish;
    end
  endtask

  // expected operand from the forwarding rule
  function automatic quad_t expect_operand(input reg_addr_t src, input logic odd_pipe);
    quad_t val;
    logic found;
    val = ref_regs[src];
    found = 1'b0;
    for (int s = 0; s < stages; s++) begin
      if (!found) begin
        if (odd_pipe) begin
          if (fw_wr_odd[s] && fw_addr_odd[s] == src) begin
            val = fw_data_odd[s];
            found = 1'b1;
          end else if (fw_wr_even[s] && fw_addr_even[s] == src) begin
            val = fw_data_even[s];
            found = 1'b1;
          end
        end else begin
          if (fw_wr_even[s] && fw_addr_even[s] == src) begin
            val = fw_data_even[s];
            found = 1'b1;
          end else if (fw_wr_odd[s] && fw_addr_odd[s] == src) begin
            val = fw_data_odd[s];
            found = 1'b1;
          end
        end
      end
    end
    return val;
  endfunction

  `include "tb_tasks.svh"

  initial begin
    clear_inputs();
    for (int i = 0; i < num_regs; i++) begin
      ref_regs[i] = '0;
    end
    wait_falls(8, "end of reset");
    rst = 1'b0;
    test_reset_state();
    test_write_read();
    test_forward_priority();
    test_disabled_entry();
    test_flush();
    test_random();
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- rf_stage_top.sv
`timescale 1ns/1ns

module rf_stage_top #(
  parameter int num_fw_stages = rf_pkg::num_fw_stages
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              flush,

  input  rf_pkg::instr_t    full_instr_even,
  input  rf_pkg::instr_id_t instr_id_even,
  input  rf_pkg::reg_addr_t reg_dst_even,
  input  rf_pkg::unit_id_t  unit_id_even,
  input  rf_pkg::latency_t  latency_even,
  input  logic              reg_wr_even,
  input  rf_pkg::reg_addr_t ra_addr_even,
  input  rf_pkg::reg_addr_t rb_addr_even,
  input  rf_pkg::reg_addr_t rc_addr_even,

  input  rf_pkg::instr_t    full_instr_odd,
  input  rf_pkg::instr_id_t instr_id_odd,
  input  rf_pkg::reg_addr_t reg_dst_odd,
  input  rf_pkg::unit_id_t  unit_id_odd,
  input  rf_pkg::latency_t  latency_odd,
  input  logic              reg_wr_odd,
  input  rf_pkg::reg_addr_t ra_addr_odd,
  input  rf_pkg::reg_addr_t rb_addr_odd,
  input  rf_pkg::reg_addr_t rc_addr_odd,

  // in-flight results, index 0 is stage 2
  input  logic              fw_wr_even   [0:num_fw_stages-1],
  input  rf_pkg::reg_addr_t fw_addr_even [0:num_fw_stages-1],
  input  rf_pkg::quad_t     fw_data_even [0:num_fw_stages-1],
  input  logic              fw_wr_odd    [0:num_fw_stages-1],
  input  rf_pkg::reg_addr_t fw_addr_odd  [0:num_fw_stages-1],
  input  rf_pkg::quad_t     fw_data_odd  [0:num_fw_stages-1],

  input  logic              wr_en_1,
  input  logic              wr_en_2,
  input  rf_pkg::reg_addr_t wr_addr_1,
  input  rf_pkg::reg_addr_t wr_addr_2,
  input  rf_pkg::quad_t     wr_data_1,
  input  rf_pkg::quad_t     wr_data_2,

  output rf_pkg::instr_t    out_full_instr_even,
  output rf_pkg::instr_id_t out_instr_id_even,
  output rf_pkg::reg_addr_t out_reg_dst_even,
  output rf_pkg::unit_id_t  out_unit_id_even,
  output rf_pkg::latency_t  out_latency_even,
  output logic              out_reg_wr_even,
  output rf_pkg::quad_t     ra_data_even,
  output rf_pkg::quad_t     rb_data_even,
  output rf_pkg::quad_t     rc_data_even,

  output rf_pkg::instr_t    out_full_instr_odd,
  output rf_pkg::instr_id_t out_instr_id_odd,
  output rf_pkg::reg_addr_t out_reg_dst_odd,
  output rf_pkg::unit_id_t  out_unit_id_odd,
  output rf_pkg::latency_t  out_latency_odd,
  output logic              out_reg_wr_odd,
  output rf_pkg::quad_t     ra_data_odd,
  output rf_pkg::quad_t     rb_data_odd,
  output rf_pkg::quad_t     rc_data_odd
);

  import rf_pkg::*;

  // ports 0..2 even ra/rb/rc, 3..5 odd ra/rb/rc
  reg_addr_t src_addr [0:5];
  quad_t     rf_rd    [0:5];
  quad_t     op_sel   [0:5];

  assign src_addr[0] = ra_addr_even;
  assign src_addr[1] = rb_addr_even;
  assign src_addr[2] = rc_addr_even;
  assign src_addr[3] = ra_addr_odd;
  assign src_addr[4] = rb_addr_odd;
  assign src_addr[5] = rc_addr_odd;

  reg_file u_reg_file (
    .clk       (clk),
    .rst       (rst),
    .wr_en_1   (wr_en_1),
    .wr_en_2   (wr_en_2),
    .wr_addr_1 (wr_addr_1),
    .wr_addr_2 (wr_addr_2),
    .wr_data_1 (wr_data_1),
    .wr_data_2 (wr_data_2),
    .rd_addr   (src_addr),
    .rd_data   (rf_rd)
  );

  for (genvar i = 0; i < 6; i++) begin : g_fwd
    if (i < 3) begin : g_even
      operand_forward #(.num_fw_stages(num_fw_stages)) u_fwd (
        .src_addr   (src_addr[i]),
        .rf_data    (rf_rd[i]),
        .own_wr     (fw_wr_even),
        .own_addr   (fw_addr_even),
        .own_data   (fw_data_even),
        .other_wr   (fw_wr_odd),
        .other_addr (fw_addr_odd),
        .other_data (fw_data_odd),
        .operand    (op_sel[i])
      );
    end else begin : g_odd
      // odd pipe sees its own stages first
      operand_forward #(.num_fw_stages(num_fw_stages)) u_fwd (
        .src_addr   (src_addr[i]),
        .rf_data    (rf_rd[i]),
        .own_wr     (fw_wr_odd),
        .own_addr   (fw_addr_odd),
        .own_data   (fw_data_odd),
        .other_wr   (fw_wr_even),
        .other_addr (fw_addr_even),
        .other_data (fw_data_even),
        .operand    (op_sel[i])
      );
    end
  end

  pipe_stage_reg #(.nop_id(even_nop_id)) u_even_reg (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .full_instr     (full_instr_even),
    .instr_id       (instr_id_even),
    .reg_dst        (reg_dst_even),
    .unit_id        (unit_id_even),
    .latency        (latency_even),
    .reg_wr         (reg_wr_even),
    .ra_op          (op_sel[0]),
    .rb_op          (op_sel[1]),
    .rc_op          (op_sel[2]),
    .out_full_instr (out_full_instr_even),
    .out_instr_id   (out_instr_id_even),
    .out_reg_dst    (out_reg_dst_even),
    .out_unit_id    (out_unit_id_even),
    .out_latency    (out_latency_even),
    .out_reg_wr     (out_reg_wr_even),
    .ra_data        (ra_data_even),
    .rb_data        (rb_data_even),
    .rc_data        (rc_data_even)
  );

  pipe_stage_reg #(.nop_id(odd_nop_id)) u_odd_reg (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .full_instr     (full_instr_odd),
    .instr_id       (instr_id_odd),
    .reg_dst        (reg_dst_odd),
    .unit_id        (unit_id_odd),
    .latency        (latency_odd),
    .reg_wr         (reg_wr_odd),
    .ra_op          (op_sel[3]),
    .rb_op          (op_sel[4]),
    .rc_op          (op_sel[5]),
    .out_full_instr (out_full_instr_odd),
    .out_instr_id   (out_instr_id_odd),
    .out_reg_dst    (out_reg_dst_odd),
    .out_unit_id    (out_unit_id_odd),
    .out_latency    (out_latency_odd),
    .out_reg_wr     (out_reg_wr_odd),
    .ra_data        (ra_data_odd),
    .rb_data        (rb_data_odd),
    .rc_data        (rc_data_odd)
  );

endmodule

//--- pipe_stage_reg.sv
`timescale 1ns/1ns

module pipe_stage_reg #(
  parameter rf_pkg::instr_id_t nop_id = rf_pkg::even_nop_id
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              flush,
  input  rf_pkg::instr_t    full_instr,
  input  rf_pkg::instr_id_t instr_id,
  input  rf_pkg::reg_addr_t reg_dst,
  input  rf_pkg::unit_id_t  unit_id,
  input  rf_pkg::latency_t  latency,
  input  logic              reg_wr,
  input  rf_pkg::quad_t     ra_op,
  input  rf_pkg::quad_t     rb_op,
  input  rf_pkg::quad_t     rc_op,
  output rf_pkg::instr_t    out_full_instr,
  output rf_pkg::instr_id_t out_instr_id,
  output rf_pkg::reg_addr_t out_reg_dst,
  output rf_pkg::unit_id_t  out_unit_id,
  output rf_pkg::latency_t  out_latency,
  output logic              out_reg_wr,
  output rf_pkg::quad_t     ra_data,
  output rf_pkg::quad_t     rb_data,
  output rf_pkg::quad_t     rc_data
);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_full_instr <= '0;
      out_instr_id <= '0;
      out_reg_dst <= '0;
      out_unit_id <= '0;
      out_latency <= '0;
      out_reg_wr <= 1'b0;
      ra_data <= '0;
      rb_data <= '0;
      rc_data <= '0;
    end else if (flush) begin
      // bubble, only the id is nonzero
      out_full_instr <= '0;
      out_instr_id <= nop_id;
      out_reg_dst <= '0;
      out_unit_id <= '0;
      out_latency <= '0;
      out_reg_wr <= 1'b0;
      ra_data <= '0;
      rb_data <= '0;
      rc_data <= '0;
    end else begin
      out_full_instr <= full_instr;
      out_instr_id <= instr_id;
      out_reg_dst <= reg_dst;
      out_unit_id <= unit_id;
      out_latency <= latency;
      out_reg_wr <= reg_wr;
      ra_data <= ra_op;
      rb_data <= rb_op;
      rc_data <= rc_op;
    end
  end

endmodule

//--- operand_forward.sv
`timescale 1ns/1ns

module operand_forward #(
  parameter int num_fw_stages = rf_pkg::num_fw_stages
) (
  input  rf_pkg::reg_addr_t src_addr,
  input  rf_pkg::quad_t     rf_data,
  input  logic              own_wr     [0:num_fw_stages-1],
  input  rf_pkg::reg_addr_t own_addr   [0:num_fw_stages-1],
  input  rf_pkg::quad_t     own_data   [0:num_fw_stages-1],
  input  logic              other_wr   [0:num_fw_stages-1],
  input  rf_pkg::reg_addr_t other_addr [0:num_fw_stages-1],
  input  rf_pkg::quad_t     other_data [0:num_fw_stages-1],
  output rf_pkg::quad_t     operand
);

  // youngest stage first, first hit is kept
  always_comb begin
    logic hit;
    hit = 1'b0;
    operand = rf_data;
    for (int i = 0; i < num_fw_stages; i++) begin
      if (!hit) begin
        // own pipe has priority within a stage
        if (own_wr[i] && (own_addr[i] == src_addr)) begin
          operand = own_data[i];
          hit = 1'b1;
        end else if (other_wr[i] && (other_addr[i] == src_addr)) begin
          operand = other_data[i];
          hit = 1'b1;
        end
      end
    end
  end

endmodule

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  logic              wr_en_1,
  input  logic              wr_en_2,
  input  rf_pkg::reg_addr_t wr_addr_1,
  input  rf_pkg::reg_addr_t wr_addr_2,
  input  rf_pkg::quad_t     wr_data_1,
  input  rf_pkg::quad_t     wr_data_2,
  input  rf_pkg::reg_addr_t rd_addr [0:5],
  output rf_pkg::quad_t     rd_data [0:5]
);

  import rf_pkg::*;

  quad_t mem [0:num_regs-1];

  // port 2 written last so it wins on a shared address
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (wr_en_1) begin
        mem[wr_addr_1] <= wr_data_1;
      end
      if (wr_en_2) begin
        mem[wr_addr_2] <= wr_data_2;
      end
    end
  end

  // read before write within a cycle
  always_comb begin
    for (int p = 0; p < 6; p++) begin
      rd_data[p] = mem[rd_addr[p]];
    end
  end

endmodule

//--- rf_pkg.sv
package rf_pkg;

  // datapath widths
  localparam int data_width = 128;
  localparam int addr_width = 7;
  localparam int instr_width = 32;

  localparam int num_regs = 128;

  // stages 2..7 of each pipe, index 0 is stage 2
  localparam int num_fw_stages = 6;

  typedef logic [0:addr_width-1] reg_addr_t;
  typedef logic [0:data_width-1] quad_t;

  // decoded instruction fields
  typedef logic [0:instr_width-1] instr_t;
  typedef logic [0:6] instr_id_t;
  typedef logic [0:2] unit_id_t;
  typedef logic [0:3] latency_t;

  // bubble ids per pipe
  localparam instr_id_t even_nop_id = 7'd86;
  localparam instr_id_t odd_nop_id = 7'd85;

endpackage
